//--- fpu_cfg.svh
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// Float format, single-precision layout
`define FPU_EXP_W   8
`define FPU_MANT_W  23
`define FPU_BIAS    127

// Operand register file
`define FPU_NREGS   16

// Wishbone word addresses
`define FPU_ADDR_CMD     16
`define FPU_ADDR_STATUS  17
`define FPU_WB_ADR_W     5

`endif

//--- fpu_pkg.sv
`default_nettype none
`include "fpu_cfg.svh"

package fpu_pkg;

    localparam int WORD_W = 1 + `FPU_EXP_W + `FPU_MANT_W;
    localparam int REG_AW = $clog2(`FPU_NREGS);

    typedef struct packed {
        logic                   sign;
        logic [`FPU_EXP_W-1:0]  exp;
        logic [`FPU_MANT_W-1:0] mantis;
    } float_fields_t;

    // Host sees raw bits, core sees fields
    typedef union packed {
        logic [WORD_W-1:0] raw;
        float_fields_t     f;
    } float_word_u;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } fpu_op_e;

    // Low bits of the command write
    typedef struct packed {
        fpu_op_e           op;
        logic [REG_AW-1:0] dst;
        logic [REG_AW-1:0] src_a;
        logic [REG_AW-1:0] src_b;
    } fpu_cmd_t;

    typedef struct packed {
        logic              req;
        logic              we;
        logic [REG_AW-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } rf_req_t;

endpackage

`default_nettype wire

//--- fpu_core.sv
`default_nettype none
`include "fpu_cfg.svh"

module fpu_core (
    input  wire fpu_pkg::float_word_u a,
    input  wire fpu_pkg::float_word_u b,
    input  wire fpu_pkg::fpu_op_e     op,
    output fpu_pkg::float_word_u      result
);

    localparam int MW   = `FPU_MANT_W;
    localparam int EW   = `FPU_EXP_W;
    localparam int SW   = MW + 1;
    localparam int LZ_W = $clog2(SW);
    localparam int XW   = EW + 2;

    fpu_pkg::float_fields_t fa;
    fpu_pkg::float_fields_t fb;
    fpu_pkg::float_fields_t hi;
    fpu_pkg::float_fields_t lo;
    fpu_pkg::float_fields_t add_res;
    fpu_pkg::float_fields_t mul_res;

    logic [EW-1:0]   shift;
    logic [SW-1:0]   sig_hi;
    logic [SW-1:0]   sig_lo;
    logic [SW:0]     sum;
    logic [SW:0]     sum_shl;
    logic [LZ_W-1:0] lz;
    logic [2*SW-1:0] prod;
    logic [XW-1:0]   exp_mul;

    always_comb begin
        fa = a.f;
        fb = b.f;
        // Subtract is add with b negated
        if (op == fpu_pkg::OP_SUB) begin
            fb.sign = ~fb.sign;
        end

        // Larger magnitude gives exponent and sign
        if ({fa.exp, fa.mantis} >= {fb.exp, fb.mantis}) begin
            hi = fa;
            lo = fb;
        end else begin
            hi = fb;
            lo = fa;
        end

        shift  = hi.exp - lo.exp;
        sig_hi = {1'b1, hi.mantis};
        sig_lo = {1'b1, lo.mantis} >> shift;

        if (hi.sign == lo.sign) begin
            sum = {1'b0, sig_hi} + {1'b0, sig_lo};
        end else begin
            sum = {1'b0, sig_hi} - {1'b0, sig_lo};
        end

        // Leading one search, highest set bit wins
        lz = '0;
        for (int i = 0; i < SW; i++) begin
            if (sum[i]) begin
                lz = LZ_W'(SW - 1 - i);
            end
        end
        sum_shl = sum << lz;

        if (fa.exp == '0) begin
            add_res = fb;
        end else if (fb.exp == '0) begin
            add_res = fa;
        end else if (sum == '0) begin
            add_res = '0;
        end else if (sum[SW]) begin
            add_res.sign   = hi.sign;
            add_res.exp    = hi.exp + 1'b1;
            add_res.mantis = sum[MW:1];
        end else begin
            add_res.sign   = hi.sign;
            add_res.exp    = hi.exp - EW'(lz);
            add_res.mantis = sum_shl[MW-1:0];
        end

        // 24x24 significand product, top bit decides the normalization
        prod    = {1'b1, fa.mantis} * {1'b1, fb.mantis};
        exp_mul = XW'(fa.exp) + XW'(fb.exp) + XW'(prod[2*SW-1]) - XW'(`FPU_BIAS);

        if (fa.exp == '0 || fb.exp == '0) begin
            mul_res = '0;
        end else begin
            mul_res.sign = fa.sign ^ fb.sign;
            mul_res.exp  = exp_mul[EW-1:0];
            if (prod[2*SW-1]) begin
                mul_res.mantis = prod[2*SW-2 -: MW];
            end else begin
                mul_res.mantis = prod[2*SW-3 -: MW];
            end
        end

        result.f = (op == fpu_pkg::OP_MUL) ? mul_res : add_res;
    end

endmodule

`default_nettype wire

//--- fpu_regfile.sv
`default_nettype none
`include "fpu_cfg.svh"

module fpu_regfile (
    input  wire                          clk,
    input  wire                          reset,
    input  wire fpu_pkg::rf_req_t        req,
    output logic [fpu_pkg::WORD_W-1:0]   rdata
);

    logic [fpu_pkg::WORD_W-1:0] mem [`FPU_NREGS];

    // One access per cycle, read data lands on the next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FPU_NREGS; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else if (req.req) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rdata <= mem[req.addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- regfile_arbiter.sv
`default_nettype none

module regfile_arbiter (
    input  wire                   clk,
    input  wire                   reset,
    input  wire fpu_pkg::rf_req_t host_req,
    input  wire fpu_pkg::rf_req_t seq_req,
    output logic                  host_gnt,
    output logic                  seq_gnt,
    output fpu_pkg::rf_req_t      rf_req
);

    // High when the sequencer wins the next tie
    logic prio_seq;

    always_comb begin
        host_gnt = 1'b0;
        seq_gnt  = 1'b0;
        if (host_req.req && seq_req.req) begin
            if (prio_seq) begin
                seq_gnt = 1'b1;
            end else begin
                host_gnt = 1'b1;
            end
        end else begin
            host_gnt = host_req.req;
            seq_gnt  = seq_req.req;
        end

        rf_req     = seq_gnt ? seq_req : host_req;
        rf_req.req = host_gnt || seq_gnt;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_seq <= 1'b0;
        end else if (host_gnt) begin
            prio_seq <= 1'b1;
        end else if (seq_gnt) begin
            prio_seq <= 1'b0;
        end
    end

    ap_one_grant: assert property (
        @(posedge clk) disable iff (reset) !(host_gnt && seq_gnt)
    );

    ap_gnt_has_req: assert property (
        @(posedge clk) disable iff (reset)
        (host_gnt |-> host_req.req) and (seq_gnt |-> seq_req.req)
    );

endmodule

`default_nettype wire

//--- wb_host_port.sv
`default_nettype none
`include "fpu_cfg.svh"

module wb_host_port (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             cyc,
    input  wire                             stb,
    input  wire                             we,
    input  wire [`FPU_WB_ADR_W-1:0]         adr,
    input  wire [fpu_pkg::WORD_W-1:0]       dat_w,
    output logic [fpu_pkg::WORD_W-1:0]      dat_r,
    output logic                            ack,
    output fpu_pkg::rf_req_t                rf_req,
    input  wire                             rf_gnt,
    input  wire [fpu_pkg::WORD_W-1:0]       rf_rdata,
    output fpu_pkg::fpu_cmd_t               cmd,
    output logic                            cmd_valid,
    input  wire                             cmd_ready,
    input  wire                             busy,
    input  wire [7:0]                       done_count
);

    localparam int AW = `FPU_WB_ADR_W;
    localparam logic [AW-1:0] ADR_NREGS  = AW'(`FPU_NREGS);
    localparam logic [AW-1:0] ADR_CMD    = AW'(`FPU_ADDR_CMD);
    localparam logic [AW-1:0] ADR_STATUS = AW'(`FPU_ADDR_STATUS);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ,
        ST_RDATA,
        ST_ACK,
        ST_CMD
    } state_e;

    state_e                     state;
    logic [fpu_pkg::WORD_W-1:0] status_word;

    assign status_word = {16'd0, done_count, 7'd0, busy};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cyc && stb) begin
                        if (adr < ADR_NREGS) begin
                            state <= ST_REQ;
                        end else if (we && adr == ADR_CMD) begin
                            state <= ST_CMD;
                        end else begin
                            state <= ST_ACK;
                        end
                    end
                end
                ST_REQ: begin
                    if (rf_gnt) begin
                        state <= we ? ST_ACK : ST_RDATA;
                    end
                end
                ST_RDATA: state <= ST_ACK;
                // Held here while the sequencer is busy
                ST_CMD: begin
                    if (cmd_ready) begin
                        state <= ST_ACK;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Status and unmapped reads answer straight from idle
    always_ff @(posedge clk) begin
        if (state == ST_RDATA) begin
            dat_r <= rf_rdata;
        end else if (state == ST_IDLE) begin
            dat_r <= (!we && adr == ADR_STATUS) ? status_word : '0;
        end
    end

    always_comb begin
        rf_req.req   = (state == ST_REQ);
        rf_req.we    = we;
        rf_req.addr  = adr[fpu_pkg::REG_AW-1:0];
        rf_req.wdata = dat_w;
    end

    assign cmd       = fpu_pkg::fpu_cmd_t'(dat_w[$bits(fpu_pkg::fpu_cmd_t)-1:0]);
    assign cmd_valid = (state == ST_CMD);
    assign ack       = (state == ST_ACK) && cyc && stb;

    // Ack closes a cycle that was already open the cycle before
    ap_ack_in_cycle: assert property (
        @(posedge clk) disable iff (reset)
        ack |-> cyc && stb && $past(cyc && stb)
    );

endmodule

`default_nettype wire

//--- fpu_sequencer.sv
`default_nettype none

module fpu_sequencer (
    input  wire                        clk,
    input  wire                        reset,
    input  wire fpu_pkg::fpu_cmd_t     cmd,
    input  wire                        cmd_valid,
    output logic                       cmd_ready,
    output fpu_pkg::rf_req_t           rf_req,
    input  wire                        rf_gnt,
    input  wire [fpu_pkg::WORD_W-1:0]  rf_rdata,
    output fpu_pkg::float_word_u       core_a,
    output fpu_pkg::float_word_u       core_b,
    output fpu_pkg::fpu_op_e           core_op,
    input  wire fpu_pkg::float_word_u  core_result,
    output logic                       busy,
    output logic [7:0]                 done_count
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_A,
        S_DATA_A,
        S_RD_B,
        S_EXEC,
        S_WR
    } state_e;

    state_e               state;
    fpu_pkg::fpu_cmd_t    cmd_q;
    fpu_pkg::float_word_u op_a;
    fpu_pkg::float_word_u res_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            done_count <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_valid) begin
                        state <= S_RD_A;
                    end
                end
                S_RD_A: begin
                    if (rf_gnt) begin
                        state <= S_DATA_A;
                    end
                end
                S_DATA_A: state <= S_RD_B;
                S_RD_B: begin
                    if (rf_gnt) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: state <= S_WR;
                S_WR: begin
                    if (rf_gnt) begin
                        state      <= S_IDLE;
                        done_count <= done_count + 8'd1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && cmd_valid) begin
            cmd_q <= cmd;
        end
        if (state == S_DATA_A) begin
            op_a <= fpu_pkg::float_word_u'(rf_rdata);
        end
        // B arrives and is used in the same cycle
        if (state == S_EXEC) begin
            res_q <= core_result;
        end
    end

    always_comb begin
        rf_req.req   = (state == S_RD_A) || (state == S_RD_B) || (state == S_WR);
        rf_req.we    = (state == S_WR);
        rf_req.wdata = res_q.raw;
        case (state)
            S_RD_B:  rf_req.addr = cmd_q.src_b;
            S_WR:    rf_req.addr = cmd_q.dst;
            default: rf_req.addr = cmd_q.src_a;
        endcase
    end

    assign cmd_ready = (state == S_IDLE);
    assign busy      = (state != S_IDLE);
    assign core_a    = op_a;
    assign core_b    = fpu_pkg::float_word_u'(rf_rdata);
    assign core_op   = cmd_q.op;

    // No grant and so no regfile write while idle
    ap_no_idle_write: assert property (
        @(posedge clk) disable iff (reset)
        rf_gnt |-> busy && rf_req.req
    );

endmodule

`default_nettype wire

//--- fpu_top.sv
`default_nettype none
`include "fpu_cfg.svh"

module fpu_top (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         cyc,
    input  wire                         stb,
    input  wire                         we,
    input  wire [`FPU_WB_ADR_W-1:0]     adr,
    input  wire [fpu_pkg::WORD_W-1:0]   dat_w,
    output logic [fpu_pkg::WORD_W-1:0]  dat_r,
    output logic                        ack
);

    fpu_pkg::rf_req_t           host_rf_req;
    fpu_pkg::rf_req_t           seq_rf_req;
    fpu_pkg::rf_req_t           rf_req;
    logic                       host_gnt;
    logic                       seq_gnt;
    logic [fpu_pkg::WORD_W-1:0] rf_rdata;

    fpu_pkg::fpu_cmd_t          cmd;
    logic                       cmd_valid;
    logic                       cmd_ready;
    logic                       busy;
    logic [7:0]                 done_count;

    fpu_pkg::float_word_u       core_a;
    fpu_pkg::float_word_u       core_b;
    fpu_pkg::fpu_op_e           core_op;
    fpu_pkg::float_word_u       core_result;

    wb_host_port host_i (
        .clk        (clk),
        .reset      (reset),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .rf_req     (host_rf_req),
        .rf_gnt     (host_gnt),
        .rf_rdata   (rf_rdata),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .busy       (busy),
        .done_count (done_count)
    );

    fpu_sequencer seq_i (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .rf_req      (seq_rf_req),
        .rf_gnt      (seq_gnt),
        .rf_rdata    (rf_rdata),
        .core_a      (core_a),
        .core_b      (core_b),
        .core_op     (core_op),
        .core_result (core_result),
        .busy        (busy),
        .done_count  (done_count)
    );

    regfile_arbiter arb_i (
        .clk      (clk),
        .reset    (reset),
        .host_req (host_rf_req),
        .seq_req  (seq_rf_req),
        .host_gnt (host_gnt),
        .seq_gnt  (seq_gnt),
        .rf_req   (rf_req)
    );

    fpu_regfile rf_i (
        .clk   (clk),
        .reset (reset),
        .req   (rf_req),
        .rdata (rf_rdata)
    );

    fpu_core core_i (
        .a      (core_a),
        .b      (core_b),
        .op     (core_op),
        .result (core_result)
    );

endmodule

`default_nettype wire

//--- tb_fpu_top.sv
`default_nettype none
`include "fpu_cfg.svh"

module tb_fpu_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_POLLS  = 16;
    localparam int NUM_OPS    = 22;
    // Loads, readbacks and status reads outside of the operations
    localparam int PLAIN_TXN  = 90;
    localparam int TXN_BUDGET = PLAIN_TXN + NUM_OPS * (2 + MAX_POLLS);

    localparam longint      HIDDEN = longint'(1) << 23;
    localparam logic [31:0] F_1P0  = 32'h3f80_0000;
    localparam logic [31:0] F_1P5  = 32'h3fc0_0000;
    localparam logic [31:0] F_0P75 = 32'h3f40_0000;
    localparam logic [31:0] F_M2P5 = 32'hc020_0000;

    logic        clk = 1'b0;
    logic        reset;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [4:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;

    logic [31:0] ref_regs [`FPU_NREGS];
    int          ops_issued;
    integer      seed;

    fpu_top dut_i (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h",
                                name, actual, expected));
        end
    endtask

    // Truncating float rules, 1/8/23 layout with bias 127
    function automatic logic [31:0] fp_model(input logic [31:0] a, input logic [31:0] b,
                                             input fpu_pkg::fpu_op_e op);
        logic        sa;
        logic        sb;
        logic        sh;
        int          ea;
        int          eb;
        int          eh;
        int          el;
        int          lz;
        int          exp_r;
        longint      mh;
        longint      ml;
        longint      sum;
        longint      prod;
        logic [31:0] res;
        sa = a[31];
        sb = (op == fpu_pkg::OP_SUB) ? ~b[31] : b[31];
        ea = int'(a[30:23]);
        eb = int'(b[30:23]);
        if (op == fpu_pkg::OP_MUL) begin
            if (ea == 0 || eb == 0) begin
                res = 32'h0;
            end else begin
                prod = (longint'(a[22:0]) + HIDDEN) * (longint'(b[22:0]) + HIDDEN);
                if (prod >= HIDDEN * HIDDEN * 2) begin
                    exp_r = ea + eb - `FPU_BIAS + 1;
                    sum   = prod >> 24;
                end else begin
                    exp_r = ea + eb - `FPU_BIAS;
                    sum   = prod >> 23;
                end
                res = {sa ^ sb, 8'(exp_r), 23'(sum)};
            end
        end else if (ea == 0) begin
            res = {sb, b[30:0]};
        end else if (eb == 0) begin
            res = a;
        end else begin
            if (a[30:0] >= b[30:0]) begin
                sh = sa;
                eh = ea;
                el = eb;
                mh = longint'(a[22:0]) + HIDDEN;
                ml = longint'(b[22:0]) + HIDDEN;
            end else begin
                sh = sb;
                eh = eb;
                el = ea;
                mh = longint'(b[22:0]) + HIDDEN;
                ml = longint'(a[22:0]) + HIDDEN;
            end
            ml  = (eh - el > 31) ? 0 : ml >> (eh - el);
            sum = (sa == sb) ? mh + ml : mh - ml;
            if (sum == 0) begin
                res = 32'h0;
            end else if (sum >= 2 * HIDDEN) begin
                res = {sh, 8'(eh + 1), 23'(sum >> 1)};
            end else begin
                lz = 0;
                while (sum < HIDDEN) begin
                    sum = sum << 1;
                    lz++;
                end
                res = {sh, 8'(eh - lz), 23'(sum)};
            end
        end
        return res;
    endfunction

    // Exponent kept in 64..190 so results stay in range
    function automatic logic [31:0] rand_float();
        logic        sign;
        int          exp_v;
        logic [31:0] mant;
        sign  = $random(seed) & 1;
        exp_v = 64 + ($unsigned($random(seed)) % 127);
        mant  = $random(seed);
        return {sign, 8'(exp_v), mant[22:0]};
    endfunction

    task automatic bus_cycle(input logic write, input int addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = 5'(addr);
        dat_w = wdata;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        rdata = dat_r;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
    endtask

    task automatic wb_write(input int addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input int addr, output logic [31:0] data);
        bus_cycle(1'b0, addr, 32'h0, data);
    endtask

    task automatic write_reg(input int idx, input logic [31:0] value);
        wb_write(idx, value);
        ref_regs[idx] = value;
    endtask

    task automatic expect_reg(input int idx);
        logic [31:0] data;
        wb_read(idx, data);
        check($sformatf("r%0d", idx), data, ref_regs[idx]);
    endtask

    task automatic issue_op(input fpu_pkg::fpu_op_e op, input int dst, input int src_a,
                            input int src_b);
        logic [31:0] expected;
        expected = fp_model(ref_regs[src_a], ref_regs[src_b], op);
        wb_write(`FPU_ADDR_CMD, {18'd0, op, 4'(dst), 4'(src_a), 4'(src_b)});
        ref_regs[dst] = expected;
        ops_issued++;
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = 32'h1;
        while (status[0] && polls < MAX_POLLS) begin
            wb_read(`FPU_ADDR_STATUS, status);
            polls++;
        end
        if (status[0]) begin
            abort_run("Operation still busy after the status polling limit");
        end
    endtask

    task automatic run_op(input fpu_pkg::fpu_op_e op, input int dst, input int src_a,
                          input int src_b);
        issue_op(op, dst, src_a, src_b);
        wait_idle();
        expect_reg(dst);
    endtask

    task automatic regfile_readback();
        logic [31:0] status;
        wb_read(`FPU_ADDR_STATUS, status);
        check("status", status, 32'h0);
        expect_reg(0);
        for (int i = 0; i < `FPU_NREGS; i++) begin
            write_reg(i, 32'h1357_9bdf ^ (i * 32'h0101_0101));
        end
        for (int i = 0; i < `FPU_NREGS; i++) begin
            expect_reg(i);
        end
    endtask

    task automatic add_ops();
        check("model 1.5+1.5", fp_model(F_1P5, F_1P5, fpu_pkg::OP_ADD), 32'h4040_0000);
        write_reg(0, F_1P5);
        write_reg(1, F_1P0);
        write_reg(2, F_0P75);
        write_reg(3, F_M2P5);
        // Mantissa carry bumps the exponent
        run_op(fpu_pkg::OP_ADD, 4, 0, 0);
        run_op(fpu_pkg::OP_ADD, 5, 1, 2);
        run_op(fpu_pkg::OP_ADD, 6, 3, 3);
        write_reg(7, rand_float());
        write_reg(8, rand_float());
        run_op(fpu_pkg::OP_ADD, 9, 7, 8);
    endtask

    task automatic sub_ops();
        write_reg(13, 32'h0);
        run_op(fpu_pkg::OP_SUB, 10, 4, 2);
        run_op(fpu_pkg::OP_ADD, 11, 0, 3);
        run_op(fpu_pkg::OP_SUB, 12, 0, 0);
        check("r12 cancel", ref_regs[12], 32'h0);
        run_op(fpu_pkg::OP_SUB, 14, 13, 0);
        write_reg(7, rand_float());
        write_reg(8, rand_float());
        run_op(fpu_pkg::OP_SUB, 9, 7, 8);
    endtask

    task automatic mul_ops();
        check("model 1.5*1.5", fp_model(F_1P5, F_1P5, fpu_pkg::OP_MUL), 32'h4010_0000);
        run_op(fpu_pkg::OP_MUL, 10, 0, 0);
        run_op(fpu_pkg::OP_MUL, 11, 0, 3);
        run_op(fpu_pkg::OP_MUL, 12, 3, 3);
        run_op(fpu_pkg::OP_MUL, 14, 1, 4);
        run_op(fpu_pkg::OP_MUL, 15, 0, 13);
        for (int i = 0; i < 2; i++) begin
            write_reg(7, rand_float());
            write_reg(8, rand_float());
            run_op(fpu_pkg::OP_MUL, 9, 7, 8);
        end
    endtask

    task automatic cmd_backpressure();
        logic [31:0] status;
        logic [7:0]  base;
        write_reg(7, rand_float());
        write_reg(8, rand_float());
        wb_read(`FPU_ADDR_STATUS, status);
        base = status[15:8];
        issue_op(fpu_pkg::OP_ADD, 9, 7, 8);
        // Second command depends on the first result
        issue_op(fpu_pkg::OP_MUL, 10, 9, 0);
        wb_read(`FPU_ADDR_STATUS, status);
        check("status.busy", status[0], 32'h1);
        check("status.count", status[15:8], base + 8'd1);
        wait_idle();
        expect_reg(9);
        expect_reg(10);
        wb_read(`FPU_ADDR_STATUS, status);
        check("status.count", status[15:8], 8'(ops_issued));
    endtask

    task automatic host_read_during_op();
        logic [31:0]      status;
        fpu_pkg::fpu_op_e op;
        for (int round = 0; round < 4; round++) begin
            write_reg(7, rand_float());
            write_reg(8, rand_float());
            op = fpu_pkg::fpu_op_e'(2'($unsigned($random(seed)) % 3));
            issue_op(op, 9, 7, 8);
            for (int r = 0; r < 6; r++) begin
                expect_reg(r);
            end
            wait_idle();
            expect_reg(9);
        end
        wb_read(`FPU_ADDR_STATUS, status);
        check("status.count", status[15:8], 8'(ops_issued));
    endtask

    initial begin
        #(TXN_BUDGET * 40 * CLK_PERIOD);
        abort_run($sformatf("Timeout: tests did not finish within %0d bus cycles",
                            TXN_BUDGET * 40));
    end

    initial begin
        seed       = 32'heb0a_8a61;
        ops_issued = 0;
        reset      = 1'b1;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;
        for (int i = 0; i < `FPU_NREGS; i++) begin
            ref_regs[i] = 32'h0;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;

        regfile_readback();
        add_ops();
        sub_ops();
        mul_ops();
        cmd_backpressure();
        host_read_during_op();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
fpu_pkg.sv
fpu_core.sv
fpu_regfile.sv
regfile_arbiter.sv
wb_host_port.sv
fpu_sequencer.sv
fpu_top.sv
tb_fpu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FPU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fpu_top \
    -f filelist.f \
    -o tb_fpu_top_sim

./obj_dir/tb_fpu_top_sim | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: fail"
    exit 1
fi
